//--- list.f
rs_pkg.sv
rs_ifs.sv
frame_buffer.sv
rs_line_encoder.sv
rs_2d_sequencer.sv
rs_2d_encoder.sv
rs_2d_checker.sv
tb_rs_2d_encoder.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rs_2d_encoder -f list.f -o sim_tb

./obj_dir/sim_tb +verilator+error+limit+1000 | tee sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0

//--- tb_rs_2d_encoder.sv
`timescale 1ns/1ps

module tb_rs_2d_encoder;
    import rs_pkg::*;

    localparam int FRAMES    = 3;
    localparam int IN_SYMS   = CODE_K * CODE_K;
    localparam int OUT_SYMS  = CODE_N * CODE_N;
    // Collect and output plus row and column passes of at most 16 cycles per line
    localparam int FRAME_CYC = IN_SYMS + OUT_SYMS + CODE_K * 16 + CODE_N * 16;
    localparam longint WATCHDOG_NS = longint'(FRAMES * FRAME_CYC * 4 * 20);

    logic clk = 1'b0;
    logic rstn;
    sym_t data_in;
    logic data_in_valid;
    logic ready;
    sym_t data_out;
    logic data_out_valid;
    logic data_out_ready;

    logic [31:0] seed = 32'h11a4_163a;
    int   in_total    = 0;
    int   out_total   = 0;
    int   frames_done = 0;
    int   tb_err      = 0;
    logic in_pending  = 1'b0;    // Offered symbol not yet taken
    logic ready_q     = 1'b1;    // ready one clock back

    rs_2d_encoder i_rs_2d_encoder (
        .clk            (clk),
        .rstn           (rstn),
        .data_in        (data_in),
        .data_in_valid  (data_in_valid),
        .ready          (ready),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready)
    );

    bind rs_2d_encoder rs_2d_checker i_rs_2d_checker (
        .clk            (clk),
        .rstn           (rstn),
        .data_in        (data_in),
        .data_in_valid  (data_in_valid),
        .ready          (ready),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // One falling-edge update with valid and ready each low about a quarter of the time
    task automatic drive_cycle();
        seed = lcg_next(seed);
        if (!in_pending) begin
            data_in_valid = (in_total < FRAMES * IN_SYMS) && (seed[31:30] != 2'b00);
            data_in       = seed[19:16];
        end
        seed = lcg_next(seed);
        data_out_ready = (seed[31:30] != 2'b00);
    endtask

    task automatic finish_run();
        int chk_err;
        chk_err = i_rs_2d_encoder.i_rs_2d_checker.err_cnt;
        $display("Checker errors: %0d, testbench errors: %0d", chk_err, tb_err);
        if (chk_err == 0 && tb_err == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        if (rstn) begin
            in_pending = data_in_valid && !ready;
            if (data_in_valid && ready) begin
                in_total = in_total + 1;
            end
            if (data_out_valid && ready) begin
                tb_err = tb_err + 1;
                $display("Output valid while the input side is open at %0t", $time);
            end
            if (data_out_valid && data_out_ready) begin
                out_total = out_total + 1;
            end
            // A frame ends when the input side reopens
            if (ready && !ready_q) begin
                frames_done = frames_done + 1;
            end
            ready_q = ready;
        end
    end

    initial begin
        rstn           = 1'b0;
        data_in        = '0;
        data_in_valid  = 1'b0;
        data_out_ready = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        while (out_total < FRAMES * OUT_SYMS) begin
            drive_cycle();
            @(negedge clk);
        end
        // Idle a little to catch stray outputs
        repeat (20) begin
            drive_cycle();
            @(negedge clk);
        end
        if (frames_done != FRAMES) begin
            tb_err = tb_err + 1;
            $display("Expected %0d frames but saw %0d", FRAMES, frames_done);
        end
        if (out_total != FRAMES * OUT_SYMS) begin
            tb_err = tb_err + 1;
            $display("Output symbol count %0d does not match three full frames", out_total);
        end
        if (in_total != FRAMES * IN_SYMS) begin
            tb_err = tb_err + 1;
            $display("Only %0d input symbols were accepted", in_total);
        end
        finish_run();
    end

    initial begin
        #(WATCHDOG_NS);
        tb_err = tb_err + 1;
        $display("Watchdog expired with %0d frames delivered", frames_done);
        finish_run();
    end

endmodule

//--- rs_2d_checker.sv
`timescale 1ns/1ps

module rs_2d_checker #(
    parameter int n = rs_pkg::CODE_N,
    parameter int k = rs_pkg::CODE_K
) (
    input logic         clk,
    input logic         rstn,
    input rs_pkg::sym_t data_in,
    input logic         data_in_valid,
    input logic         ready,
    input rs_pkg::sym_t data_out,
    input logic         data_out_valid,
    input logic         data_out_ready
);
    import rs_pkg::*;

    localparam sym_t ROOT [PAR_N] = '{4'h1, 4'h2, 4'h4, 4'h8};  // alpha^0 .. alpha^3

    int   err_cnt = 0;
    sym_t in_q [$];           // Accepted symbols of the current frame
    int   in_cnt;
    int   out_row;
    int   out_col;
    int   exp_idx;
    logic started;
    logic frame_done;         // Column syndromes complete this cycle
    sym_t hold_sym;           // data_out one cycle back
    sym_t row_syn [PAR_N];
    sym_t row_nxt [PAR_N];
    sym_t col_syn [n][PAR_N];
    sym_t exp_sym;
    logic exp_ok;
    logic row_zero;
    logic col_zero;
    logic in_xfer;
    logic out_xfer;
    logic out_end;

    assign in_xfer  = data_in_valid && ready;
    assign out_xfer = data_out_valid && data_out_ready;
    assign out_end  = out_xfer && (out_row == n - 1) && (out_col == n - 1);

    always_comb begin
        row_zero = 1'b1;
        col_zero = 1'b1;
        for (int j = 0; j < PAR_N; j++) begin
            // Horner step including the symbol now on the bus
            row_nxt[j] = gf_mul(row_syn[j], ROOT[j]) ^ data_out;
            if (row_nxt[j] != '0) begin
                row_zero = 1'b0;
            end
            for (int c = 0; c < n; c++) begin
                if (col_syn[c][j] != '0) begin
                    col_zero = 1'b0;
                end
            end
        end
        exp_idx = out_row * k + out_col;
        exp_ok  = exp_idx < in_q.size();
        exp_sym = exp_ok ? in_q[exp_idx] : '0;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            in_cnt     <= 0;
            out_row    <= 0;
            out_col    <= 0;
            started    <= 1'b0;
            frame_done <= 1'b0;
            hold_sym   <= '0;
            in_q.delete();
            for (int j = 0; j < PAR_N; j++) begin
                row_syn[j] <= '0;
                for (int c = 0; c < n; c++) begin
                    col_syn[c][j] <= '0;
                end
            end
        end else begin
            hold_sym   <= data_out;
            frame_done <= out_end;
            if (in_xfer) begin
                started <= 1'b1;
                in_cnt  <= in_cnt + 1;
                in_q.push_back(data_in);
            end
            if (frame_done) begin
                for (int j = 0; j < PAR_N; j++) begin
                    for (int c = 0; c < n; c++) begin
                        col_syn[c][j] <= '0;
                    end
                end
            end else if (out_xfer) begin
                for (int j = 0; j < PAR_N; j++) begin
                    col_syn[out_col][j] <= gf_mul(col_syn[out_col][j], ROOT[j]) ^ data_out;
                    row_syn[j] <= (out_col == n - 1) ? '0 : row_nxt[j];
                end
                out_col <= (out_col == n - 1) ? 0 : out_col + 1;
                if (out_col == n - 1) begin
                    out_row <= (out_row == n - 1) ? 0 : out_row + 1;
                end
            end
            if (out_end) begin
                in_q.delete();    // Next frame starts from an empty queue
                in_cnt <= 0;
            end
        end
    end

    a_idle: assert property (@(posedge clk) disable iff (!rstn)
        !started |-> ready && !data_out_valid)
        else begin
            err_cnt = err_cnt + 1;
            $error("Encoder not idle after reset before the first input");
        end

    a_full: assert property (@(posedge clk) disable iff (!rstn)
        in_xfer && (in_cnt == k * k - 1) |=> !ready)
        else begin
            err_cnt = err_cnt + 1;
            $error("ERR %0t ready exp 0 got %b", $time, $sampled(ready));
        end

    a_collect: assert property (@(posedge clk) disable iff (!rstn)
        ready && !(in_xfer && (in_cnt == k * k - 1)) |=> ready)
        else begin
            err_cnt = err_cnt + 1;
            $error("ERR %0t ready exp 1 got %b", $time, $sampled(ready));
        end

    a_busy: assert property (@(posedge clk) disable iff (!rstn)
        !ready && !out_end |=> !ready)
        else begin
            err_cnt = err_cnt + 1;
            $error("ERR %0t ready exp 0 got %b", $time, $sampled(ready));
        end

    a_release: assert property (@(posedge clk) disable iff (!rstn)
        out_end |=> ready)
        else begin
            err_cnt = err_cnt + 1;
            $error("ERR %0t ready exp 1 got %b", $time, $sampled(ready));
        end

    a_hold: assert property (@(posedge clk) disable iff (!rstn)
        data_out_valid && !data_out_ready |=> data_out_valid && (data_out == hold_sym))
        else begin
            err_cnt = err_cnt + 1;
            $error("ERR %0t data_out exp %h got %h (valid %b)", $time,
                   $sampled(hold_sym), $sampled(data_out), $sampled(data_out_valid));
        end

    a_data: assert property (@(posedge clk) disable iff (!rstn)
        out_xfer && (out_row < k) && (out_col < k) |-> exp_ok && (data_out == exp_sym))
        else begin
            err_cnt = err_cnt + 1;
            $error("ERR %0t data_out exp %h got %h", $time,
                   $sampled(exp_sym), $sampled(data_out));
        end

    a_row: assert property (@(posedge clk) disable iff (!rstn)
        out_xfer && (out_col == n - 1) |-> row_zero)
        else begin
            err_cnt = err_cnt + 1;
            $error("Output row %0d is not a valid codeword", $sampled(out_row));
        end

    a_col: assert property (@(posedge clk) disable iff (!rstn)
        frame_done |-> col_zero)
        else begin
            err_cnt = err_cnt + 1;
            $error("Column syndromes not all zero at the end of a frame");
        end

endmodule

//--- rs_2d_encoder.sv
`timescale 1ns/1ps

module rs_2d_encoder #(
    parameter int n = rs_pkg::CODE_N,
    parameter int k = rs_pkg::CODE_K
) (
    input  logic         clk,
    input  logic         rstn,
    input  rs_pkg::sym_t data_in,
    input  logic         data_in_valid,
    output logic         ready,
    output rs_pkg::sym_t data_out,
    output logic         data_out_valid,
    input  logic         data_out_ready
);

    frame_buf_if fbuf_if ();
    line_enc_if  enc_if ();

    frame_buffer #(
        .n(n)
    ) i_frame_buffer (
        .clk  (clk),
        .rstn (rstn),
        .fbuf (fbuf_if)
    );

    // One parity generator shared by row and column passes
    rs_line_encoder i_rs_line_encoder (
        .clk  (clk),
        .rstn (rstn),
        .enc  (enc_if)
    );

    rs_2d_sequencer #(
        .n(n),
        .k(k)
    ) i_rs_2d_sequencer (
        .clk            (clk),
        .rstn           (rstn),
        .data_in        (data_in),
        .data_in_valid  (data_in_valid),
        .ready          (ready),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready),
        .fbuf           (fbuf_if),
        .enc            (enc_if)
    );

endmodule

//--- rs_2d_sequencer.sv
`timescale 1ns/1ps

module rs_2d_sequencer #(
    parameter int n = rs_pkg::CODE_N,
    parameter int k = rs_pkg::CODE_K
) (
    input  logic         clk,
    input  logic         rstn,
    input  rs_pkg::sym_t data_in,
    input  logic         data_in_valid,
    output logic         ready,
    output rs_pkg::sym_t data_out,
    output logic         data_out_valid,
    input  logic         data_out_ready,
    frame_buf_if.ctl     fbuf,
    line_enc_if.ctl      enc
);
    import rs_pkg::*;

    localparam int STEP_W = $clog2(k + PAR_N + 1);

    localparam idx_t K_IDX  = idx_t'(k);
    localparam idx_t K_LAST = idx_t'(k - 1);
    localparam idx_t N_LAST = idx_t'(n - 1);

    // Line schedule: reads at 0..k-1, feeds at 1..k, parity out at k+1..k+PAR_N
    localparam logic [STEP_W-1:0] STEP_K    = STEP_W'(k);
    localparam logic [STEP_W-1:0] STEP_PAR  = STEP_W'(k + 1);
    localparam logic [STEP_W-1:0] STEP_LAST = STEP_W'(k + PAR_N);

    typedef enum logic [1:0] {
        COLLECT,
        ROW_PASS,
        COL_PASS,
        OUTPUT
    } state_t;

    state_t state;
    idx_t row;                // Frame row, or line index in ROW_PASS
    idx_t col;                // Frame column, or line index in COL_PASS
    logic [STEP_W-1:0] step;  // Cycle within a line
    logic [STEP_W-1:0] par_off;
    idx_t step_idx;
    idx_t nxt_row;
    idx_t nxt_col;
    logic line_pass;
    logic feed_phase;
    logic par_phase;
    logic in_xfer;
    logic out_xfer;
    logic rd_primed;          // rd_sym holds the cell at (row, col)
    logic out_last;           // Output register holds the final cell
    logic load;
    logic at_last;

    assign ready    = (state == COLLECT);
    assign in_xfer  = data_in_valid && ready;
    assign out_xfer = data_out_valid && data_out_ready;

    assign line_pass  = (state == ROW_PASS) || (state == COL_PASS);
    assign feed_phase = line_pass && (step != '0) && (step <= STEP_K);
    assign par_phase  = line_pass && (step >= STEP_PAR);
    assign par_off    = step - STEP_PAR;
    assign step_idx   = (step < STEP_K) ? idx_t'(step) : '0;

    assign enc.start  = feed_phase && (step == STEP_W'(1));
    assign enc.feed   = feed_phase;
    assign enc.sym_in = fbuf.rd_sym;
    assign enc.shift  = par_phase;

    assign at_last = (row == N_LAST) && (col == N_LAST);
    assign load    = (state == OUTPUT) && rd_primed && !out_last
                     && (!data_out_valid || data_out_ready);

    // Row-major successor, wraps to the origin after the last cell
    always_comb begin
        nxt_row = row;
        nxt_col = col + 1'b1;
        if (col == N_LAST) begin
            nxt_col = '0;
            nxt_row = (row == N_LAST) ? '0 : row + 1'b1;
        end
    end

    always_comb begin
        fbuf.wr_en  = 1'b0;
        fbuf.wr_row = row;
        fbuf.wr_col = col;
        fbuf.wr_sym = enc.par_out;
        fbuf.rd_row = row;
        fbuf.rd_col = col;
        case (state)
            COLLECT: begin
                fbuf.wr_en  = in_xfer;
                fbuf.wr_sym = data_in;
            end
            ROW_PASS: begin
                fbuf.wr_en  = par_phase;
                fbuf.wr_col = K_IDX + idx_t'(par_off);   // Parity columns k..n-1
                fbuf.rd_col = step_idx;
            end
            COL_PASS: begin
                fbuf.wr_en  = par_phase;
                fbuf.wr_row = K_IDX + idx_t'(par_off);   // Parity rows k..n-1
                fbuf.rd_row = step_idx;
            end
            default: begin
                // Look ahead so the next cell is ready the cycle after a load
                if (load) begin
                    fbuf.rd_row = nxt_row;
                    fbuf.rd_col = nxt_col;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= COLLECT;
            row   <= '0;
            col   <= '0;
            step  <= '0;
        end else begin
            case (state)
                COLLECT: begin
                    if (in_xfer) begin
                        if (col == K_LAST) begin
                            col <= '0;
                            if (row == K_LAST) begin
                                row   <= '0;
                                state <= ROW_PASS;
                            end else begin
                                row <= row + 1'b1;
                            end
                        end else begin
                            col <= col + 1'b1;
                        end
                    end
                end
                ROW_PASS: begin
                    if (step == STEP_LAST) begin
                        step <= '0;
                        if (row == K_LAST) begin
                            row   <= '0;
                            state <= COL_PASS;
                        end else begin
                            row <= row + 1'b1;
                        end
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                COL_PASS: begin
                    if (step == STEP_LAST) begin
                        step <= '0;
                        if (col == N_LAST) begin
                            col   <= '0;
                            state <= OUTPUT;
                        end else begin
                            col <= col + 1'b1;
                        end
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                default: begin
                    if (load) begin
                        row <= nxt_row;
                        col <= nxt_col;
                    end
                    if (out_xfer && out_last) begin
                        state <= COLLECT;   // Frame fully delivered
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_primed      <= 1'b0;
            data_out_valid <= 1'b0;
            out_last       <= 1'b0;
        end else begin
            rd_primed <= (state == OUTPUT);
            if (load) begin
                data_out_valid <= 1'b1;
                out_last       <= at_last;
            end else if (out_xfer) begin
                data_out_valid <= 1'b0;
                out_last       <= 1'b0;
            end
        end
    end

    // Output symbol only changes on a load, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (load) begin
            data_out <= fbuf.rd_sym;
        end
    end

endmodule

//--- rs_line_encoder.sv
`timescale 1ns/1ps

module rs_line_encoder (
    input logic     clk,
    input logic     rstn,
    line_enc_if.enc enc
);
    import rs_pkg::*;

    sym_t stage_q [PAR_N];    // Index 0 holds the x^3 remainder term
    sym_t fb;
    sym_t upper [PAR_N];      // Stage above each tap, zero on start

    // Division feedback, old remainder ignored on the first symbol
    always_comb begin
        fb = enc.start ? enc.sym_in : (enc.sym_in ^ stage_q[0]);
        for (int i = 0; i < PAR_N - 1; i++) begin
            upper[i] = enc.start ? '0 : stage_q[i + 1];
        end
        upper[PAR_N - 1] = '0;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < PAR_N; i++) begin
                stage_q[i] <= '0;
            end
        end else if (enc.feed) begin
            for (int i = 0; i < PAR_N; i++) begin
                stage_q[i] <= upper[i] ^ gf_mul(fb, GEN_COEF[i]);
            end
        end else if (enc.shift) begin
            // Parity leaves highest degree first
            for (int i = 0; i < PAR_N - 1; i++) begin
                stage_q[i] <= stage_q[i + 1];
            end
            stage_q[PAR_N - 1] <= '0;
        end
    end

    assign enc.par_out = stage_q[0];

endmodule

//--- frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer #(
    parameter int n = rs_pkg::CODE_N
) (
    input logic      clk,
    input logic      rstn,
    frame_buf_if.mem fbuf
);
    import rs_pkg::*;

    sym_t cells [n][n];    // Row-major frame storage

    always_ff @(posedge clk) begin
        if (fbuf.wr_en) begin
            cells[fbuf.wr_row][fbuf.wr_col] <= fbuf.wr_sym;
        end
    end

    // Read register, sampled every cycle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fbuf.rd_sym <= '0;
        end else begin
            fbuf.rd_sym <= cells[fbuf.rd_row][fbuf.rd_col];
        end
    end

endmodule

//--- rs_ifs.sv
`timescale 1ns/1ps

// Sequencer side drives addresses and write data, buffer returns rd_sym
interface frame_buf_if;
    import rs_pkg::*;

    logic wr_en;
    idx_t wr_row;
    idx_t wr_col;
    sym_t wr_sym;
    idx_t rd_row;
    idx_t rd_col;
    sym_t rd_sym;    // Cell at last cycle's read address

    modport ctl (output wr_en, wr_row, wr_col, wr_sym, rd_row, rd_col, input rd_sym);
    modport mem (input wr_en, wr_row, wr_col, wr_sym, rd_row, rd_col, output rd_sym);
endinterface

// Control of the shared row/column parity generator
interface line_enc_if;
    import rs_pkg::*;

    logic start;     // With feed, clears the LFSR first
    logic feed;
    sym_t sym_in;
    logic shift;
    sym_t par_out;

    modport ctl (output start, feed, sym_in, shift, input par_out);
    modport enc (input start, feed, sym_in, shift, output par_out);
endinterface

//--- rs_pkg.sv
package rs_pkg;

    parameter int SYM_W  = 4;
    parameter int IDX_W  = 4;
    parameter int CODE_N = 15;
    parameter int CODE_K = 11;
    parameter int PAR_N  = CODE_N - CODE_K;

    typedef logic [SYM_W-1:0] sym_t;
    typedef logic [IDX_W-1:0] idx_t;

    // Low bits of x^4+x+1, folded back in when x^4 falls out
    parameter sym_t GF_POLY = 4'h3;

    // g(x) = (x+1)(x+a)(x+a^2)(x+a^3) = x^4 + a^12 x^3 + a^4 x^2 + x + a^6
    parameter sym_t GEN_COEF [PAR_N] = '{4'hF, 4'h3, 4'h1, 4'hC};  // x^3 first

    // Shift-and-add multiply in GF(16)
    function automatic sym_t gf_mul(input sym_t a, input sym_t b);
        sym_t acc;
        sym_t sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < SYM_W; i++) begin
            if (b[i]) begin
                acc = acc ^ sh;
            end
            // Multiply by alpha
            if (sh[SYM_W-1]) begin
                sh = {sh[SYM_W-2:0], 1'b0} ^ GF_POLY;
            end else begin
                sh = {sh[SYM_W-2:0], 1'b0};
            end
        end
        return acc;
    endfunction

endpackage
